// ==== src.f ====
hdl/mvu_pkg.sv
hdl/job_ctrl.sv
hdl/in_agu.sv
hdl/acc_retime.sv
hdl/quant_wb.sv
hdl/mvu_seq_top.sv
tb/tb_mvu_seq.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_mvu_seq -o tb_mvu_seq
	./obj_dir/tb_mvu_seq | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_mvu_seq.sv ====
// MVU sequencer testbench
// Runs three random jobs through the sequencer and checks every output
// against a cycle model of the job counter, loop counters, delay lines
// and quantizer write-back
`timescale 1ns/1ps

module tb_mvu_seq;
    import mvu_pkg::*;

    localparam int NJOBS = 3;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               quant_clr;
    job_cfg_t           cfg;
    logic               done;
    logic               irq;
    rd_addr_t           rd_addr;
    acc_ctrl_t          acc_ctrl;
    logic               quant_load;
    logic               quant_step;
    logic               wr_en;
    logic [BDBANKA-1:0] wr_addr;

    job_cfg_t    jobs [NJOBS];
    logic [31:0] lfsr_state;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;             // Zero until the jobs are known

    // Reference model state
    logic               m_busy;               // Job running, done low
    int                 m_left;               // Run cycles still to go
    logic               m_irq;
    int                 m_k1;
    int                 m_k0;
    int                 m_wb;
    int                 m_ib;
    logic [6:0]         run_h;                // Bit k is the value k+1 cycles ago
    logic [6:0]         sh_h;
    logic [6:0]         start_h;
    logic [6:0]         blk_h;
    logic               m_sh;
    logic               m_blk;
    logic               m_qload;
    int                 m_qsteps;             // Output bits still to step
    logic [BDBANKA-1:0] m_wr;
    rd_addr_t           exp_rd;
    acc_ctrl_t          exp_acc;

    mvu_seq_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .quant_clr  (quant_clr),
        .cfg        (cfg),
        .done       (done),
        .irq        (irq),
        .rd_addr    (rd_addr),
        .acc_ctrl   (acc_ctrl),
        .quant_load (quant_load),
        .quant_step (quant_step),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                // 4 ns period
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // One step per bit
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic job_cfg_t make_job(input int op_force);
        job_cfg_t c;
        int       ip;
        int       wp;
        int       op;
        int       l0;
        int       l1;
        ip = rand_bits(2) % 3 + 1;
        wp = rand_bits(2) % 3 + 1;
        op = (op_force > 0) ? op_force : rand_bits(2) % 3 + 1;
        l0 = rand_bits(2) % 3;                // Length minus one
        l1 = rand_bits(2) % 3;
        if (ip * wp * (l0 + 1) < op + 2) begin
            ip = 2;                           // Block long enough for the quantizer
            l0 = 2;
        end
        c.iprecision   = BPREC'(ip);
        c.wprecision   = BPREC'(wp);
        c.oprecision   = BPREC'(op);
        c.ibaseaddr    = BDBANKA'(rand_bits(15));
        c.wbaseaddr    = BWBANKA'(rand_bits(9));
        c.obaseaddr    = BDBANKA'(rand_bits(15));
        c.idim0.stride = BSTRIDE'(rand_bits(4));
        c.idim1.stride = BSTRIDE'(rand_bits(4));
        c.wdim0.stride = BSTRIDE'(rand_bits(4));
        c.wdim1.stride = BSTRIDE'(rand_bits(4));
        c.idim0.length = BLENGTH'(l0);
        c.idim1.length = BLENGTH'(l1);
        c.wdim0.length = BLENGTH'(l0);
        c.wdim1.length = BLENGTH'(l1);
        c.countdown    = BCNTDWN'(ip * wp * (l0 + 1) * (l1 + 1)); // Whole loop once
        return c;
    endfunction

    // Base plus stride offsets plus bit-plane, cut to bank width
    function automatic rd_addr_t addr_of(input job_cfg_t c, input int k1, input int k0,
                                         input int wb, input int ib);
        rd_addr_t a;
        int       ia;
        int       wa;
        ia = int'(c.ibaseaddr) + k1 * int'(c.idim1.stride) + k0 * int'(c.idim0.stride) + ib;
        wa = int'(c.wbaseaddr) + k1 * int'(c.wdim1.stride) + k0 * int'(c.wdim0.stride) + wb;
        a.iaddr = ia[BDBANKA-1:0];
        a.waddr = wa[BWBANKA-1:0];
        return a;
    endfunction

    assign m_sh   = m_busy && m_ib == 0 && m_wb != 0;
    assign m_blk  = m_busy && m_ib == 0 && m_wb == 0 && m_k0 == int'(cfg.idim0.length);
    assign exp_rd = addr_of(cfg, m_k1, m_k0, m_wb, m_ib);
    assign exp_acc.shacc_acc  = run_h[ACC_DELAY];            // Six cycles
    assign exp_acc.shacc_sh   = sh_h[ACC_DELAY-1];           // Five cycles
    assign exp_acc.shacc_load = start_h[ACC_DELAY] | blk_h[ACC_DELAY];

    always @(posedge clk) begin
        if (!rst_n) begin
            m_busy  <= 1'b0;
            m_left  <= 0;
            m_irq   <= 1'b0;
            m_k1    <= 0;
            m_k0    <= 0;
            m_wb    <= 0;
            m_ib    <= 0;
            run_h   <= '0;
            sh_h    <= '0;
            start_h <= '0;
            blk_h   <= '0;
            m_wr    <= '0;
        end else begin
            m_irq <= 1'b0;
            if (!m_busy && start) begin       // Start counts only when idle
                if (cfg.countdown == '0) begin
                    m_irq <= 1'b1;
                end else begin
                    m_busy <= 1'b1;
                    m_left <= int'(cfg.countdown);
                end
            end else if (m_busy) begin
                if (m_left == 1) begin
                    m_busy <= 1'b0;
                    m_irq  <= 1'b1;
                end
                m_left <= m_left - 1;
            end
            if (start && !m_busy) begin       // AGU rewinds on an accepted start
                m_k1 <= 0;
                m_k0 <= 0;
                m_wb <= int'(cfg.wprecision) - 1;
                m_ib <= int'(cfg.iprecision) - 1;
            end else if (m_busy) begin
                if (m_ib > 0) begin
                    m_ib <= m_ib - 1;
                end else begin
                    m_ib <= int'(cfg.iprecision) - 1;
                    if (m_wb > 0) begin
                        m_wb <= m_wb - 1;
                    end else begin
                        m_wb <= int'(cfg.wprecision) - 1;
                        if (m_k0 < int'(cfg.idim0.length)) begin
                            m_k0 <= m_k0 + 1;
                        end else begin
                            m_k0 <= 0;
                            m_k1 <= (m_k1 < int'(cfg.idim1.length)) ? m_k1 + 1 : 0;
                        end
                    end
                end
            end
            run_h   <= {run_h[5:0], m_busy};
            sh_h    <= {sh_h[5:0], m_sh};
            start_h <= {start_h[5:0], start && !m_busy};
            blk_h   <= {blk_h[5:0], m_blk};
            if (start_h[ACC_DELAY+MAXPOOLSTAGES]) begin
                m_wr <= cfg.obaseaddr;        // Output load, seven cycles after start
            end else if (m_qsteps != 0) begin
                m_wr <= m_wr + BDBANKA'(1);
            end
        end
        if (!rst_n || quant_clr) begin
            m_qload  <= 1'b0;
            m_qsteps <= 0;
        end else if (m_qload) begin
            m_qload  <= 1'b0;
            m_qsteps <= int'(cfg.oprecision);
        end else if (m_qsteps != 0) begin
            m_qsteps <= m_qsteps - 1;
        end else if (blk_h[ACC_DELAY+MAXPOOLSTAGES]) begin
            m_qload <= 1'b1;                  // Quantizer start while idle
        end
    end

    done_chk: assert property (@(posedge clk) disable iff (!rst_n) done == !m_busy)
        else begin
            errors = errors + 1;
            $display("Fail done expected %h got %h", $sampled(!m_busy), $sampled(done));
        end
    irq_chk: assert property (@(posedge clk) disable iff (!rst_n) irq == m_irq)
        else begin
            errors = errors + 1;
            $display("Fail irq expected %h got %h", $sampled(m_irq), $sampled(irq));
        end
    rd_chk: assert property (@(posedge clk) disable iff (!rst_n) !m_busy || rd_addr == exp_rd)
        else begin
            errors = errors + 1;
            $display("Fail rd_addr expected %h got %h", $sampled(exp_rd), $sampled(rd_addr));
        end
    acc_chk: assert property (@(posedge clk) disable iff (!rst_n) acc_ctrl == exp_acc)
        else begin
            errors = errors + 1;
            $display("Fail acc_ctrl expected %h got %h", $sampled(exp_acc), $sampled(acc_ctrl));
        end
    qload_chk: assert property (@(posedge clk) disable iff (!rst_n) quant_load == m_qload)
        else begin
            errors = errors + 1;
            $display("Fail quant_load expected %h got %h", $sampled(m_qload),
                     $sampled(quant_load));
        end
    qstep_chk: assert property (@(posedge clk) disable iff (!rst_n)
                                quant_step == (m_qsteps != 0) && wr_en == (m_qsteps != 0))
        else begin
            errors = errors + 1;
            $display("Fail quant_step/wr_en expected %h got %h/%h", $sampled(m_qsteps != 0),
                     $sampled(quant_step), $sampled(wr_en));
        end
    wr_chk: assert property (@(posedge clk) disable iff (!rst_n) wr_addr == m_wr)
        else begin
            errors = errors + 1;
            $display("Fail wr_addr expected %h got %h", $sampled(m_wr), $sampled(wr_addr));
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic run_job(input int j);
        @(negedge clk);
        cfg   = jobs[j];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (j == 1) begin
            repeat (2) @(negedge clk);
            start = 1'b1;                     // Second start while busy
            @(negedge clk);
            start = 1'b0;
        end
        if (j == 2) begin
            do @(negedge clk); while (!quant_step);
            quant_clr = 1'b1;                 // Abort in the middle of the steps
            @(negedge clk);
            quant_clr = 1'b0;
        end
        while (!done) @(negedge clk);
        repeat (20) @(negedge clk);           // Let the delay lines drain
    endtask

    initial begin
        int max_cd;
        rst_n      = 1'b0;
        start      = 1'b0;
        quant_clr  = 1'b0;
        cfg        = '0;
        lfsr_state = 32'h96dd;
        max_cd     = 0;
        for (int j = 0; j < NJOBS; j++) begin
            jobs[j] = make_job((j == 2) ? 3 : 0); // Last job steps three bits
            if (int'(jobs[j].countdown) > max_cd) begin
                max_cd = int'(jobs[j].countdown);
            end
        end
        cycle_limit = NJOBS * (10 + max_cd + 40);
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int j = 0; j < NJOBS; j++) begin
            run_job(j);
        end
        $display("Errors: %0d over %0d jobs in %0d cycles", errors, NJOBS, cycles);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== hdl/mvu_seq_top.sv ====
// MVU job sequencer top level
// Control plane of one matrix-vector lane: job control, read address
// generation, strobe retiming and quantizer write-back
`timescale 1ns/1ps

module mvu_seq_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        quant_clr,
    input  mvu_pkg::job_cfg_t           cfg,        // Held during the job
    output logic                        done,
    output logic                        irq,
    output mvu_pkg::rd_addr_t           rd_addr,
    output mvu_pkg::acc_ctrl_t          acc_ctrl,
    output logic                        quant_load,
    output logic                        quant_step,
    output logic                        wr_en,
    output logic [mvu_pkg::BDBANKA-1:0] wr_addr
);

    logic run;                                  // Job in progress
    logic sh_out;                               // AGU accumulator shift
    logic blk_done;                             // AGU end of block
    logic quant_start;                          // Retimed block done
    logic out_load;                             // Retimed job start

    job_ctrl u_job_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .countdown  (cfg.countdown),
        .run        (run),
        .done       (done),
        .irq        (irq)
    );

    in_agu u_in_agu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .run        (run),
        .cfg        (cfg),
        .rd_addr    (rd_addr),
        .sh_out     (sh_out),
        .blk_done   (blk_done)
    );

    acc_retime u_acc_retime (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .run         (run),
        .sh_out      (sh_out),
        .blk_done    (blk_done),
        .acc_ctrl    (acc_ctrl),
        .quant_start (quant_start),
        .out_load    (out_load)
    );

    quant_wb u_quant_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .quant_clr   (quant_clr),
        .quant_start (quant_start),
        .out_load    (out_load),
        .oprecision  (cfg.oprecision),
        .obaseaddr   (cfg.obaseaddr),
        .quant_load  (quant_load),
        .quant_step  (quant_step),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr)
    );

endmodule

// ==== hdl/quant_wb.sv ====
// Serial quantizer controller and output write-address generator
// Loads the quantizers, steps them once per output bit and writes
// each bit-plane to consecutive data memory addresses
`timescale 1ns/1ps

module quant_wb (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        quant_clr,    // Abort stepping
    input  logic                        quant_start,  // Ignored while busy
    input  logic                        out_load,     // Reload write base
    input  logic [mvu_pkg::BPREC-1:0]   oprecision,
    input  logic [mvu_pkg::BDBANKA-1:0] obaseaddr,
    output logic                        quant_load,
    output logic                        quant_step,
    output logic                        wr_en,
    output logic [mvu_pkg::BDBANKA-1:0] wr_addr
);
    import mvu_pkg::*;

    quant_state_e     state;
    logic [BPREC-1:0] bit_cnt;                  // Steps left minus one

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= Q_IDLE;
            bit_cnt <= '0;
        end else if (quant_clr) begin
            state   <= Q_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                Q_IDLE: begin
                    if (quant_start) begin
                        state <= Q_LOAD;
                    end
                end
                Q_LOAD: begin
                    bit_cnt <= oprecision - BPREC'(1);
                    if (oprecision == '0) begin
                        state <= Q_IDLE;        // Nothing to write out
                    end else begin
                        state <= Q_STEP;
                    end
                end
                Q_STEP: begin
                    if (bit_cnt == '0) begin
                        state <= Q_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt - BPREC'(1);
                    end
                end
                default: state <= Q_IDLE;
            endcase
        end
    end

    assign quant_load = (state == Q_LOAD);
    assign quant_step = (state == Q_STEP);
    assign wr_en      = quant_step;             // One output bit-plane per step

    // Write pointer runs across all blocks of the job
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_addr <= '0;
        end else if (out_load) begin
            wr_addr <= obaseaddr;
        end else if (quant_step) begin
            wr_addr <= wr_addr + BDBANKA'(1);
        end
    end

endmodule

// ==== hdl/acc_retime.sv ====
// Accumulator strobe retiming
// Delays the sequencer strobes so they meet the data at the
// accumulators, the quantizers and the output write port
`timescale 1ns/1ps

module acc_retime (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               run,
    input  logic               sh_out,
    input  logic               blk_done,
    output mvu_pkg::acc_ctrl_t acc_ctrl,
    output logic               quant_start,
    output logic               out_load
);
    import mvu_pkg::*;

    // Bit k of each chain holds the input from k+1 cycles ago
    logic [LOAD_DELAY-1:0]   run_sr;            // Accumulate enable
    logic [ACC_DELAY-1:0]    sh_sr;             // Bit-plane shift
    logic [QSTART_DELAY-1:0] start_sr;          // Job start, two taps
    logic [QSTART_DELAY-1:0] blk_sr;            // Block done, two taps

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_sr   <= '0;
            sh_sr    <= '0;
            start_sr <= '0;
            blk_sr   <= '0;
        end else begin
            run_sr   <= {run_sr[LOAD_DELAY-2:0], run};
            sh_sr    <= {sh_sr[ACC_DELAY-2:0], sh_out};
            start_sr <= {start_sr[QSTART_DELAY-2:0], start & ~run}; // Accepted starts only
            blk_sr   <= {blk_sr[QSTART_DELAY-2:0], blk_done};
        end
    end

    // Product arrives after memory read plus vector pipeline
    assign acc_ctrl.shacc_acc  = run_sr[LOAD_DELAY-1];
    assign acc_ctrl.shacc_sh   = sh_sr[ACC_DELAY-1];

    // Fresh load at job start and after each finished block
    assign acc_ctrl.shacc_load = start_sr[LOAD_DELAY-1] | blk_sr[LOAD_DELAY-1];

    // One more stage for the max pool
    assign quant_start = blk_sr[QSTART_DELAY-1];
    assign out_load    = start_sr[QSTART_DELAY-1];

endmodule

// ==== hdl/in_agu.sv ====
// Input and weight address generator
// Walks two loop dimensions and the bit-planes of both operands,
// giving one read address pair per run cycle with the accumulator
// shift and end-of-block marks
`timescale 1ns/1ps

module in_agu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,            // Rewind to the first address
    input  logic              run,              // Advance once per cycle
    input  mvu_pkg::job_cfg_t cfg,
    output mvu_pkg::rd_addr_t rd_addr,
    output logic              sh_out,
    output logic              blk_done
);
    import mvu_pkg::*;

    logic [BLENGTH-1:0] k1;                     // Outer dimension position
    logic [BLENGTH-1:0] k0;                     // Inner dimension position
    logic [BPREC-1:0]   wb;                     // Weight bit-plane, counts down
    logic [BPREC-1:0]   ib;                     // Input bit-plane, innermost

    logic [BPREC-1:0]   iprec_m1;
    logic [BPREC-1:0]   wprec_m1;
    logic               ib_last;
    logic               wb_last;
    logic               k0_last;
    logic               k1_last;

    logic [BDBANKA-1:0] i_off1;
    logic [BDBANKA-1:0] i_off0;
    logic [BDBANKA-1:0] i_bit;
    logic [BWBANKA-1:0] w_off1;
    logic [BWBANKA-1:0] w_off0;
    logic [BWBANKA-1:0] w_bit;

    assign iprec_m1 = cfg.iprecision - BPREC'(1);
    assign wprec_m1 = cfg.wprecision - BPREC'(1);

    assign ib_last = (ib == '0);
    assign wb_last = (wb == '0);
    assign k0_last = (k0 == cfg.idim0.length);
    assign k1_last = (k1 == cfg.idim1.length);  // W side shares the i-side lengths

    // Loop nest, innermost first: ib, wb, k0, k1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            k1 <= '0;
            k0 <= '0;
            wb <= '0;
            ib <= '0;
        end else if (start && !run) begin       // Start counts only while idle
            k1 <= '0;
            k0 <= '0;
            wb <= wprec_m1;
            ib <= iprec_m1;
        end else if (run) begin
            if (ib_last) begin
                ib <= iprec_m1;
                if (wb_last) begin
                    wb <= wprec_m1;
                    if (k0_last) begin
                        k0 <= '0;
                        if (k1_last) begin
                            k1 <= '0;           // Wrap after last combination
                        end else begin
                            k1 <= k1 + BLENGTH'(1);
                        end
                    end else begin
                        k0 <= k0 + BLENGTH'(1);
                    end
                end else begin
                    wb <= wb - BPREC'(1);
                end
            end else begin
                ib <= ib - BPREC'(1);
            end
        end
    end

    // Input side offsets, wrap at data bank width
    assign i_off1 = k1 * cfg.idim1.stride;
    assign i_off0 = k0 * cfg.idim0.stride;
    assign i_bit  = {{(BDBANKA-BPREC){1'b0}}, ib};

    // Weight side offsets, low bits only
    assign w_off1 = k1[BWBANKA-1:0] * cfg.wdim1.stride[BWBANKA-1:0];
    assign w_off0 = k0[BWBANKA-1:0] * cfg.wdim0.stride[BWBANKA-1:0];
    assign w_bit  = {{(BWBANKA-BPREC){1'b0}}, wb};

    assign rd_addr.iaddr = cfg.ibaseaddr + i_off1 + i_off0 + i_bit;
    assign rd_addr.waddr = cfg.wbaseaddr + w_off1 + w_off0 + w_bit;

    // Shift between weight bit-planes, not after the last one
    assign sh_out   = run & ib_last & ~wb_last;

    // Last product of the final k0 position closes the block
    assign blk_done = run & ib_last & wb_last & k0_last;

endmodule

// ==== hdl/job_ctrl.sv ====
// Job controller
// Counts down the configured number of run cycles after a start,
// then raises done and pulses the interrupt for one cycle
`timescale 1ns/1ps

module job_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,      // Accepted only when idle
    input  logic [mvu_pkg::BCNTDWN-1:0] countdown,
    output logic                        run,
    output logic                        done,
    output logic                        irq
);
    import mvu_pkg::*;

    job_state_e         state;
    logic [BCNTDWN-1:0] cnt;                        // Remaining run cycles minus one

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= JOB_IDLE;
            cnt   <= '0;
            irq   <= 1'b0;
        end else begin
            irq <= 1'b0;                            // Default one-cycle pulse
            case (state)
                JOB_IDLE: begin
                    if (start) begin
                        if (countdown == '0) begin
                            irq <= 1'b1;            // Empty job finishes at once
                        end else begin
                            state <= JOB_RUN;
                            cnt   <= countdown - BCNTDWN'(1);
                        end
                    end
                end
                JOB_RUN: begin
                    if (cnt == '0) begin
                        state <= JOB_IDLE;
                        irq   <= 1'b1;              // Lines up with done rising
                    end else begin
                        cnt <= cnt - BCNTDWN'(1);
                    end
                end
                default: state <= JOB_IDLE;
            endcase
        end
    end

    assign run  = (state == JOB_RUN);
    assign done = (state == JOB_IDLE);

endmodule

// ==== hdl/mvu_pkg.sv ====
// MVU sequencer package
// Widths, pipeline latencies, job configuration and control structs,
// and the state encodings shared by the sequencer blocks
package mvu_pkg;

    // Bus and field widths
    localparam int BDBANKA = 15;                  // Data bank address
    localparam int BWBANKA = 9;                   // Weight bank address
    localparam int BPREC   = 6;                   // Precision fields
    localparam int BCNTDWN = 29;                  // Job countdown
    localparam int BSTRIDE = 15;                  // Stride fields
    localparam int BLENGTH = 15;                  // Length fields, value is length minus one

    // Datapath latencies seen by the control strobes
    localparam int VVPSTAGES     = 3;             // Vector product pipeline
    localparam int MEMRDLATENCY  = 2;             // Weight/data memory read
    localparam int MAXPOOLSTAGES = 1;             // Max pool pipeline
    localparam int ACC_DELAY     = VVPSTAGES + MEMRDLATENCY;
    localparam int LOAD_DELAY    = ACC_DELAY + 1;              // Accumulator load/acc strobes
    localparam int QSTART_DELAY  = LOAD_DELAY + MAXPOOLSTAGES; // Quantizer start, output load

    typedef struct packed {
        logic [BSTRIDE-1:0] stride;
        logic [BLENGTH-1:0] length;               // Actual length minus one
    } dim_cfg_t;

    typedef struct packed {
        logic [BCNTDWN-1:0] countdown;            // Run cycles for the job
        logic [BPREC-1:0]   iprecision;
        logic [BPREC-1:0]   wprecision;
        logic [BPREC-1:0]   oprecision;
        logic [BDBANKA-1:0] ibaseaddr;
        logic [BWBANKA-1:0] wbaseaddr;
        logic [BDBANKA-1:0] obaseaddr;
        dim_cfg_t           idim0;                // Inner input dimension
        dim_cfg_t           idim1;                // Outer input dimension
        dim_cfg_t           wdim0;                // Only stride used
        dim_cfg_t           wdim1;                // Only stride used
    } job_cfg_t;

    typedef struct packed {
        logic [BDBANKA-1:0] iaddr;
        logic [BWBANKA-1:0] waddr;
    } rd_addr_t;

    typedef struct packed {
        logic shacc_load;                         // Load accumulator from product
        logic shacc_acc;                          // Accumulate
        logic shacc_sh;                           // Shift for next bit-plane
    } acc_ctrl_t;

    typedef enum logic {JOB_IDLE, JOB_RUN} job_state_e;

    typedef enum logic [1:0] {Q_IDLE, Q_LOAD, Q_STEP} quant_state_e;

endpackage
